/* tb/qdq_stim.txt */
// Per test: instruction word, 4 FP32 input rows, 4 int32 accumulator rows,
// 4 expected int8 rows (sign extended) and 4 expected FP32 rows, lane 0 first
// Test 0: fractions, saturation, infinity, NaN, zero, denormal, large integers
12340056
3F800000 40200000 C0700000 3F000000 42FFCCCD 43000000 C3000000 C3480000
7F800000 FF800000 7FC00000 FFC00000 00000000 80000000 00000001 BF7FBE77
00000000 00000001 FFFFFFFF 00000002 00000003 FFFFFF9C 000000FF 000003E8
01000000 01000001 7FFFFFFF 80000000 FFFFFFF9 00FFFFFF FDFFFFFD 0000000C
00000001 00000002 FFFFFFFD 00000000 0000007F 0000007F FFFFFF80 FFFFFF80
0000007F FFFFFF80 0000007F FFFFFF80 00000000 00000000 00000000 00000000
00000000 3F800000 BF800000 40000000 40400000 C2C80000 437F0000 447A0000
4B800000 4B800000 4EFFFFFF CF000000 C0E00000 4B7FFFFF CC000000 41400000
// Test 1: mixed signs, near-limit values, truncated mantissas
BEEF0A5C
40400000 BF800000 42C98000 C2C70000 42800000 C2800000 3FC00000 BFC00000
501502F9 D01502F9 42FE0000 C2FE0000 3F400000 412E6666 C0E66666 40000000
00000005 FFFFFFFB 00000006 00000007 00000400 FFFFFC00 00000064 0000FFFF
12345678 EDCBA988 00000008 FFFFFFFE 00000000 40000000 C0000000 00000010
00000003 FFFFFFFF 00000064 FFFFFF9D 00000040 FFFFFFC0 00000001 FFFFFFFF
0000007F FFFFFF80 0000007F FFFFFF81 00000000 0000000A FFFFFFF9 00000002
40A00000 C0A00000 40C00000 40E00000 44800000 C4800000 42C80000 477FFF00
4D91A2B3 CD91A2B3 41000000 C0000000 00000000 4E800000 CE800000 41800000

/* mlsu_qdq_top.f */
source/mlsu_pkg.sv
source/lsu_sequencer.sv
source/fp_quantizer.sv
source/int_dequantizer.sv
source/row_store_buffer.sv
source/mlsu_qdq_top.sv
tb/tb_mlsu_qdq.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_mlsu_qdq -f mlsu_qdq_top.f -o sim_mlsu_qdq
./obj_dir/sim_mlsu_qdq | tee sim.log
if grep -qx "Simulation completed successfully" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi

/* tb/tb_mlsu_qdq.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mlsu_qdq import mlsu_pkg::*; ();

  localparam int NUM_LANES       = 4;
  localparam int NUM_ROWS        = 4;
  localparam int ROW_W           = NUM_LANES * LANE_W;
  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 2;
  localparam int LANES_PER_MAT   = NUM_ROWS * NUM_LANES;
  localparam int WORDS_PER_TEST  = 1 + 4 * LANES_PER_MAT;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;

  // Sections of one test record in the stim file
  localparam int SEC_IN  = 0;
  localparam int SEC_ACC = 1;
  localparam int SEC_QNT = 2;
  localparam int SEC_DQ  = 3;

  logic clk;
  logic rstnn;
  logic inst_fifo_rready_i;
  logic [INST_W-1:0] inst_fifo_rdata_i;
  logic inst_fifo_rrequest_o;
  logic operation_finish_o;
  logic mi_sinst_wvalid_o;
  logic [LSU_INST_W-1:0] mi_sinst_wdata_o;
  logic mi_sinst_wready_i;
  logic mi_sload_row_wvalid_i;
  logic [ROW_W-1:0] mi_sload_row_wdata_i;
  logic mi_sload_row_wready_o;
  logic mi_sstore_row_rvalid_i;
  logic mi_sstore_row_rready_o;
  logic mi_sstore_row_rlast_o;
  logic [ROW_W-1:0] mi_sstore_row_rdata_o;
  logic mo_sinst_wvalid_o;
  logic [LSU_INST_W-1:0] mo_sinst_wdata_o;
  logic mo_sinst_wready_i;
  logic mo_sload_row_wvalid_i;
  logic [ROW_W-1:0] mo_sload_row_wdata_i;
  logic mo_sload_row_wready_o;
  logic mo_sstore_row_rvalid_i;
  logic mo_sstore_row_rready_o;
  logic mo_sstore_row_rlast_o;
  logic [ROW_W-1:0] mo_sstore_row_rdata_o;

  logic [LANE_W-1:0] stim_mem [NUM_TESTS*WORDS_PER_TEST];
  logic [INST_W-1:0] cur_inst;
  int seed;
  int err_cnt;
  int mon_err_cnt;
  int pass_cnt;
  int fail_cnt;
  int mi_inst_cnt;
  int mo_inst_cnt;
  int rreq_cnt;

  mlsu_qdq_top #(.NUM_LANES(NUM_LANES), .NUM_ROWS(NUM_ROWS)) u_dut (
    .clk                    (clk),
    .rstnn                  (rstnn),
    .inst_fifo_rready_i     (inst_fifo_rready_i),
    .inst_fifo_rdata_i      (inst_fifo_rdata_i),
    .inst_fifo_rrequest_o   (inst_fifo_rrequest_o),
    .operation_finish_o     (operation_finish_o),
    .mi_sinst_wvalid_o      (mi_sinst_wvalid_o),
    .mi_sinst_wdata_o       (mi_sinst_wdata_o),
    .mi_sinst_wready_i      (mi_sinst_wready_i),
    .mi_sload_row_wvalid_i  (mi_sload_row_wvalid_i),
    .mi_sload_row_wdata_i   (mi_sload_row_wdata_i),
    .mi_sload_row_wready_o  (mi_sload_row_wready_o),
    .mi_sstore_row_rvalid_i (mi_sstore_row_rvalid_i),
    .mi_sstore_row_rready_o (mi_sstore_row_rready_o),
    .mi_sstore_row_rlast_o  (mi_sstore_row_rlast_o),
    .mi_sstore_row_rdata_o  (mi_sstore_row_rdata_o),
    .mo_sinst_wvalid_o      (mo_sinst_wvalid_o),
    .mo_sinst_wdata_o       (mo_sinst_wdata_o),
    .mo_sinst_wready_i      (mo_sinst_wready_i),
    .mo_sload_row_wvalid_i  (mo_sload_row_wvalid_i),
    .mo_sload_row_wdata_i   (mo_sload_row_wdata_i),
    .mo_sload_row_wready_o  (mo_sload_row_wready_o),
    .mo_sstore_row_rvalid_i (mo_sstore_row_rvalid_i),
    .mo_sstore_row_rready_o (mo_sstore_row_rready_o),
    .mo_sstore_row_rlast_o  (mo_sstore_row_rlast_o),
    .mo_sstore_row_rdata_o  (mo_sstore_row_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Reference rules
  // ----------------------------------------------------------------------

  // FP32 to int8 with round toward zero and saturation
  function automatic logic [LANE_W-1:0] quant_ref(input logic [LANE_W-1:0] word);
    lane_t       lane;
    int          e;
    logic [31:0] sig;
    int          q;
    lane = word;
    e = int'(lane.fp.exp);
    // Covers infinity and NaN as well
    if (e >= FP_EXP_BIAS + 7) begin
      q = lane.fp.sign ? -128 : 127;
    end else if (e < FP_EXP_BIAS) begin
      q = 0;
    end else begin
      sig = {8'd0, 1'b1, lane.fp.mant};
      q = int'(sig >> (23 + FP_EXP_BIAS - e));
      if (lane.fp.sign) begin
        q = -q;
      end
    end
    return q;
  endfunction

  // Signed int32 to FP32 with truncated low bits
  function automatic logic [LANE_W-1:0] dequant_ref(input logic [LANE_W-1:0] word);
    lane_t  res;
    longint m;
    int     p;
    m = longint'($signed(word));
    if (m < 0) begin
      m = -m;
    end
    p = 0;
    for (int b = 0; b < 32; b++) begin
      if (m[b]) begin
        p = b;
      end
    end
    res.fp.sign = word[31];
    res.fp.exp  = 8'(p + FP_EXP_BIAS);
    if (p >= 23) begin
      res.fp.mant = 23'(m >> (p - 23));
    end else begin
      res.fp.mant = 23'(m << (23 - p));
    end
    if (m == 0) begin
      res = '0;
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [ROW_W-1:0] stim_row(input int t, input int sec, input int r);
    logic [ROW_W-1:0] row;
    int               base;
    base = t * WORDS_PER_TEST + 1 + (sec * NUM_ROWS + r) * NUM_LANES;
    for (int g = 0; g < NUM_LANES; g++) begin
      row[g*LANE_W +: LANE_W] = stim_mem[base + g];
    end
    return row;
  endfunction

  task automatic report_mismatch(input string sig, input logic [ROW_W-1:0] exp_v,
                                 input logic [ROW_W-1:0] act_v);
    $display("FAIL t=%0t %s expected=%0h actual=%0h", $time, sig, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    err_cnt++;
  endtask

  task automatic close_test(input string what, input int errs_before);
    int errs;
    errs = err_cnt + mon_err_cnt - errs_before;
    if (errs == 0) begin
      pass_cnt++;
      $display("Test %s: ok", what);
    end else begin
      fail_cnt++;
      $display("Test %s: %0d errors", what, errs);
    end
  endtask

  task automatic check_stim_rules();
    int base;
    for (int t = 0; t < NUM_TESTS; t++) begin
      base = t * WORDS_PER_TEST + 1;
      for (int i = 0; i < LANES_PER_MAT; i++) begin
        if (stim_mem[base + 2*LANES_PER_MAT + i] !== quant_ref(stim_mem[base + i])) begin
          report_mismatch($sformatf("stim quant test %0d lane %0d", t, i),
                          ROW_W'(quant_ref(stim_mem[base + i])),
                          ROW_W'(stim_mem[base + 2*LANES_PER_MAT + i]));
        end
        if (stim_mem[base + 3*LANES_PER_MAT + i] !==
            dequant_ref(stim_mem[base + LANES_PER_MAT + i])) begin
          report_mismatch($sformatf("stim dequant test %0d lane %0d", t, i),
                          ROW_W'(dequant_ref(stim_mem[base + LANES_PER_MAT + i])),
                          ROW_W'(stim_mem[base + 3*LANES_PER_MAT + i]));
        end
      end
    end
  endtask

  task automatic expect_bit(input string sig, input logic act_v, input logic exp_v);
    if (act_v !== exp_v) begin
      report_mismatch(sig, ROW_W'(exp_v), ROW_W'(act_v));
    end
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = err_cnt + mon_err_cnt;
    expect_bit("mi_sinst_wvalid_o", mi_sinst_wvalid_o, 1'b0);
    expect_bit("mo_sinst_wvalid_o", mo_sinst_wvalid_o, 1'b0);
    expect_bit("mi_sload_row_wready_o", mi_sload_row_wready_o, 1'b0);
    expect_bit("mo_sload_row_wready_o", mo_sload_row_wready_o, 1'b0);
    expect_bit("mi_sstore_row_rready_o", mi_sstore_row_rready_o, 1'b0);
    expect_bit("mo_sstore_row_rready_o", mo_sstore_row_rready_o, 1'b0);
    expect_bit("inst_fifo_rrequest_o", inst_fifo_rrequest_o, 1'b0);
    expect_bit("operation_finish_o", operation_finish_o, 1'b1);
    close_test("0 reset state", errs_before);
  endtask

  // One store port cycle with rows compared oldest first
  task automatic check_store(input string port, input int t, input int sec,
                             input logic rvalid, input logic rready, input logic rlast,
                             input logic [ROW_W-1:0] rdata, inout int got);
    logic exp_last;
    exp_last = rready && (got == NUM_ROWS - 1);
    if (rready && got >= NUM_ROWS) begin
      report_problem({port, " offers a row after the whole matrix was stored"});
    end
    if (rlast !== exp_last) begin
      report_mismatch({port, "_rlast_o"}, ROW_W'(exp_last), ROW_W'(rlast));
    end
    // Offered row must hold through rvalid gaps
    if (rready && got < NUM_ROWS) begin
      if (rdata !== stim_row(t, sec, got)) begin
        report_mismatch($sformatf("%s_rdata_o[row %0d]", port, got),
                        stim_row(t, sec, got), rdata);
      end
      if (rvalid) begin
        got++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // One instruction through both paths
  // ----------------------------------------------------------------------

  task automatic run_test(input int t);
    int  errs_before;
    int  mi_sent;
    int  mo_sent;
    int  mi_got;
    int  mo_got;
    int  mi_inst_before;
    int  mo_inst_before;
    int  rreq_before;
    logic done;
    errs_before    = err_cnt + mon_err_cnt;
    mi_inst_before = mi_inst_cnt;
    mo_inst_before = mo_inst_cnt;
    rreq_before    = rreq_cnt;
    mi_sent = 0;
    mo_sent = 0;
    mi_got  = 0;
    mo_got  = 0;
    done    = 1'b0;
    cur_inst = stim_mem[t * WORDS_PER_TEST];
    inst_fifo_rdata_i  = cur_inst;
    inst_fifo_rready_i = 1'b1;
    while (!done) begin
      @(negedge clk);
      // Ready and store outputs come from flops and are stable here
      mi_sload_row_wvalid_i = (mi_sent < NUM_ROWS);
      mo_sload_row_wvalid_i = (mo_sent < NUM_ROWS);
      if (mi_sent < NUM_ROWS) begin
        mi_sload_row_wdata_i = stim_row(t, SEC_IN, mi_sent);
      end
      if (mo_sent < NUM_ROWS) begin
        mo_sload_row_wdata_i = stim_row(t, SEC_ACC, mo_sent);
      end
      if (mi_sload_row_wvalid_i && mi_sload_row_wready_o) begin
        mi_sent++;
      end
      if (mo_sload_row_wvalid_i && mo_sload_row_wready_o) begin
        mo_sent++;
      end
      mi_sstore_row_rvalid_i = (($random(seed) & 3) != 0);
      mo_sstore_row_rvalid_i = (($random(seed) & 3) != 0);
      check_store("mi_sstore_row", t, SEC_QNT, mi_sstore_row_rvalid_i,
                  mi_sstore_row_rready_o, mi_sstore_row_rlast_o, mi_sstore_row_rdata_o,
                  mi_got);
      check_store("mo_sstore_row", t, SEC_DQ, mo_sstore_row_rvalid_i,
                  mo_sstore_row_rready_o, mo_sstore_row_rlast_o, mo_sstore_row_rdata_o,
                  mo_got);
      if (inst_fifo_rrequest_o) begin
        if (mi_got != NUM_ROWS || mo_got != NUM_ROWS) begin
          report_problem("instruction popped before both store streams finished");
        end
        inst_fifo_rready_i = 1'b0;
        done = 1'b1;
      end
    end
    mi_sload_row_wvalid_i  = 1'b0;
    mo_sload_row_wvalid_i  = 1'b0;
    mi_sstore_row_rvalid_i = 1'b0;
    mo_sstore_row_rvalid_i = 1'b0;
    repeat (2) @(negedge clk);
    if (mi_inst_cnt - mi_inst_before != 1) begin
      report_problem($sformatf("%0d mi_ instruction pulses instead of one",
                               mi_inst_cnt - mi_inst_before));
    end
    if (mo_inst_cnt - mo_inst_before != 1) begin
      report_problem($sformatf("%0d mo_ instruction pulses instead of one",
                               mo_inst_cnt - mo_inst_before));
    end
    if (rreq_cnt - rreq_before != 1) begin
      report_problem($sformatf("%0d FIFO pops instead of one", rreq_cnt - rreq_before));
    end
    expect_bit("operation_finish_o", operation_finish_o, 1'b1);
    close_test($sformatf("%0d instruction %h", t + 1, cur_inst), errs_before);
  endtask

  // Issue strobes and pops sampled once the cycle's inputs have settled
  always begin
    @(negedge clk);
    #(CLK_PERIOD / 4);
    if (mi_sinst_wvalid_o) begin
      mi_inst_cnt++;
      if (mi_sinst_wdata_o !== {cur_inst[INFO_W-1:0], OPC_READ}) begin
        $display("FAIL t=%0t mi_sinst_wdata_o expected=%h actual=%h", $time,
                 {cur_inst[INFO_W-1:0], OPC_READ}, mi_sinst_wdata_o);
        mon_err_cnt++;
      end
    end
    if (mo_sinst_wvalid_o) begin
      mo_inst_cnt++;
      if (mo_sinst_wdata_o !== {cur_inst[INST_W-1:INFO_W], OPC_WRITE}) begin
        $display("FAIL t=%0t mo_sinst_wdata_o expected=%h actual=%h", $time,
                 {cur_inst[INST_W-1:INFO_W], OPC_WRITE}, mo_sinst_wdata_o);
        mon_err_cnt++;
      end
    end
    if (inst_fifo_rrequest_o) begin
      rreq_cnt++;
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rstnn                  = 1'b0;
    inst_fifo_rready_i     = 1'b0;
    inst_fifo_rdata_i      = '0;
    mi_sinst_wready_i      = 1'b1;
    mo_sinst_wready_i      = 1'b1;
    mi_sload_row_wvalid_i  = 1'b0;
    mo_sload_row_wvalid_i  = 1'b0;
    mi_sload_row_wdata_i   = '0;
    mo_sload_row_wdata_i   = '0;
    mi_sstore_row_rvalid_i = 1'b0;
    mo_sstore_row_rvalid_i = 1'b0;
    cur_inst = '0;
    seed     = 32'h3f79c4f5;
    $readmemh("tb/qdq_stim.txt", stim_mem);
    check_stim_rules();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstnn = 1'b1;
    @(negedge clk);
    check_reset_state();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             pass_cnt, fail_cnt, err_cnt + mon_err_cnt);
    if (fail_cnt == 0 && err_cnt + mon_err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/mlsu_qdq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mlsu_qdq_top import mlsu_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int NUM_ROWS  = 4
) (
  input  wire                          clk,
  input  wire                          rstnn,

  // Instruction FIFO and status
  input  wire                          inst_fifo_rready_i,
  input  wire [INST_W-1:0]             inst_fifo_rdata_i,
  output wire                          inst_fifo_rrequest_o,
  output wire                          operation_finish_o,

  // Input matrix LSU
  output wire                          mi_sinst_wvalid_o,
  output wire [LSU_INST_W-1:0]         mi_sinst_wdata_o,
  input  wire                          mi_sinst_wready_i,
  input  wire                          mi_sload_row_wvalid_i,
  input  wire [NUM_LANES*LANE_W-1:0]   mi_sload_row_wdata_i,
  output wire                          mi_sload_row_wready_o,
  input  wire                          mi_sstore_row_rvalid_i,
  output wire                          mi_sstore_row_rready_o,
  output wire                          mi_sstore_row_rlast_o,
  output wire [NUM_LANES*LANE_W-1:0]   mi_sstore_row_rdata_o,

  // Output matrix LSU
  output wire                          mo_sinst_wvalid_o,
  output wire [LSU_INST_W-1:0]         mo_sinst_wdata_o,
  input  wire                          mo_sinst_wready_i,
  input  wire                          mo_sload_row_wvalid_i,
  input  wire [NUM_LANES*LANE_W-1:0]   mo_sload_row_wdata_i,
  output wire                          mo_sload_row_wready_o,
  input  wire                          mo_sstore_row_rvalid_i,
  output wire                          mo_sstore_row_rready_o,
  output wire                          mo_sstore_row_rlast_o,
  output wire [NUM_LANES*LANE_W-1:0]   mo_sstore_row_rdata_o
);

  localparam int ROW_W = NUM_LANES * LANE_W;

  logic [INFO_W-1:0] in_info;
  logic [INFO_W-1:0] out_info;
  logic              start;
  logic              pending;
  logic              q_idle;
  logic              dq_idle;
  logic              both_idle;

  // ----------------------------------------------------------------------
  // Instruction decode and issue
  // ----------------------------------------------------------------------

  // Output info in the upper half, input info in the lower half
  assign in_info  = inst_fifo_rdata_i[INFO_W-1:0];
  assign out_info = inst_fifo_rdata_i[INST_W-1:INFO_W];

  assign both_idle = q_idle & dq_idle;
  assign start = both_idle & ~pending & inst_fifo_rready_i &
                 mi_sinst_wready_i & mo_sinst_wready_i;

  // Sequencers leave IDLE right after start, so this is a single pulse
  assign mi_sinst_wvalid_o = start;
  assign mo_sinst_wvalid_o = start;
  assign mi_sinst_wdata_o  = {in_info, OPC_READ};
  assign mo_sinst_wdata_o  = {out_info, OPC_WRITE};

  // Pop once both paths are back in IDLE
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      pending <= 1'b0;
    end else if (start) begin
      pending <= 1'b1;
    end else if (both_idle) begin
      pending <= 1'b0;
    end
  end

  assign inst_fifo_rrequest_o = pending & both_idle;
  assign operation_finish_o   = both_idle & ~pending;

  // ----------------------------------------------------------------------
  // Quantization path
  // ----------------------------------------------------------------------

  logic             q_row_fire;
  logic             q_valid;
  logic [ROW_W-1:0] q_row;
  logic             qa_full;
  logic             qa_done;

  lsu_sequencer #(.NUM_ROWS(NUM_ROWS)) u_q_seq (
    .clk          (clk),
    .rstnn        (rstnn),
    .start_i      (start),
    .row_wvalid_i (mi_sload_row_wvalid_i),
    .row_wready_o (mi_sload_row_wready_o),
    .row_fire_o   (q_row_fire),
    .buf_full_i   (qa_full),
    .store_done_i (qa_done),
    .idle_o       (q_idle)
  );

  fp_quantizer #(.NUM_LANES(NUM_LANES)) u_quant (
    .clk     (clk),
    .rstnn   (rstnn),
    .valid_i (q_row_fire),
    .row_i   (mi_sload_row_wdata_i),
    .valid_o (q_valid),
    .row_o   (q_row)
  );

  row_store_buffer #(.NUM_LANES(NUM_LANES), .NUM_ROWS(NUM_ROWS)) u_qa_buf (
    .clk          (clk),
    .rstnn        (rstnn),
    .wvalid_i     (q_valid),
    .wdata_i      (q_row),
    .full_o       (qa_full),
    .rvalid_i     (mi_sstore_row_rvalid_i),
    .rready_o     (mi_sstore_row_rready_o),
    .rlast_o      (mi_sstore_row_rlast_o),
    .rdata_o      (mi_sstore_row_rdata_o),
    .store_done_o (qa_done)
  );

  // ----------------------------------------------------------------------
  // Dequantization path
  // ----------------------------------------------------------------------

  logic             dq_row_fire;
  logic             dq_valid;
  logic [ROW_W-1:0] dq_row;
  logic             out_full;
  logic             out_done;

  lsu_sequencer #(.NUM_ROWS(NUM_ROWS)) u_dq_seq (
    .clk          (clk),
    .rstnn        (rstnn),
    .start_i      (start),
    .row_wvalid_i (mo_sload_row_wvalid_i),
    .row_wready_o (mo_sload_row_wready_o),
    .row_fire_o   (dq_row_fire),
    .buf_full_i   (out_full),
    .store_done_i (out_done),
    .idle_o       (dq_idle)
  );

  int_dequantizer #(.NUM_LANES(NUM_LANES)) u_dequant (
    .clk     (clk),
    .rstnn   (rstnn),
    .valid_i (dq_row_fire),
    .row_i   (mo_sload_row_wdata_i),
    .valid_o (dq_valid),
    .row_o   (dq_row)
  );

  row_store_buffer #(.NUM_LANES(NUM_LANES), .NUM_ROWS(NUM_ROWS)) u_out_buf (
    .clk          (clk),
    .rstnn        (rstnn),
    .wvalid_i     (dq_valid),
    .wdata_i      (dq_row),
    .full_o       (out_full),
    .rvalid_i     (mo_sstore_row_rvalid_i),
    .rready_o     (mo_sstore_row_rready_o),
    .rlast_o      (mo_sstore_row_rlast_o),
    .rdata_o      (mo_sstore_row_rdata_o),
    .store_done_o (out_done)
  );

endmodule

`default_nettype wire

/* source/row_store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module row_store_buffer import mlsu_pkg::*; #(
  parameter int NUM_LANES = 4,
  parameter int NUM_ROWS  = 4
) (
  input  wire                         clk,
  input  wire                         rstnn,
  input  wire                         wvalid_i,
  input  wire  [NUM_LANES*LANE_W-1:0] wdata_i,
  output logic                        full_o,
  input  wire                         rvalid_i,
  output logic                        rready_o,
  output logic                        rlast_o,
  output logic [NUM_LANES*LANE_W-1:0] rdata_o,
  output logic                        store_done_o
);

  localparam int ROW_W = NUM_LANES * LANE_W;
  localparam int CNT_W = $clog2(NUM_ROWS + 1);
  localparam int IDX_W = $clog2(NUM_ROWS);

  logic [ROW_W-1:0] rows_q [NUM_ROWS];
  logic [CNT_W-1:0] wr_cnt;
  logic [CNT_W-1:0] rd_cnt;
  logic             row_write;
  logic             row_move;
  logic             last_move;

  // ----------------------------------------------------------------------
  // Fill side
  // ----------------------------------------------------------------------

  // Writes past full are dropped since the pipeline has no back-pressure
  assign row_write = wvalid_i & ~full_o;
  assign full_o    = (wr_cnt == CNT_W'(NUM_ROWS));

  always_ff @(posedge clk) begin
    if (row_write) begin
      rows_q[wr_cnt[IDX_W-1:0]] <= wdata_i;
    end
  end

  // ----------------------------------------------------------------------
  // Store side
  // ----------------------------------------------------------------------

  // Whole matrix present means rows are waiting to go
  assign rready_o  = full_o;
  assign row_move  = rvalid_i & rready_o;
  assign rlast_o   = rready_o & (rd_cnt == CNT_W'(NUM_ROWS - 1));
  assign last_move = row_move & rlast_o;

  // Held steady while rvalid stays low
  assign rdata_o = rows_q[rd_cnt[IDX_W-1:0]];

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      wr_cnt       <= '0;
      rd_cnt       <= '0;
      store_done_o <= 1'b0;
    end else begin
      store_done_o <= last_move;
      if (last_move) begin
        // Empty again for the next matrix
        wr_cnt <= '0;
        rd_cnt <= '0;
      end else begin
        if (row_write) begin
          wr_cnt <= wr_cnt + 1'b1;
        end
        if (row_move) begin
          rd_cnt <= rd_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/int_dequantizer.sv */
`timescale 1ns/1ps
`default_nettype none

module int_dequantizer import mlsu_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  wire                        clk,
  input  wire                        rstnn,
  input  wire                        valid_i,
  input  wire [NUM_LANES*LANE_W-1:0] row_i,
  output logic                       valid_o,
  output wire [NUM_LANES*LANE_W-1:0] row_o
);

  localparam int LEAD_W = $clog2(LANE_W);

  logic valid_s1;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      valid_s1 <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      valid_s1 <= valid_i;
      valid_o  <= valid_s1;
    end
  end

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_t             lane_in;
    lane_t             lane_out;
    logic [LANE_W-1:0] mag;
    logic [LEAD_W-1:0] lead;
    logic              s1_sign;
    logic              s1_zero;
    logic [LANE_W-1:0] s1_mag;
    logic [LEAD_W-1:0] s1_lead;
    logic [LANE_W-1:0] norm;

    assign lane_in = row_i[g*LANE_W +: LANE_W];
    // Unsigned view keeps -2^31 intact
    assign mag = lane_in.int_val[LANE_W-1] ? -lane_in.int_val : lane_in.int_val;

    // Highest set bit wins
    always_comb begin
      lead = '0;
      for (int b = 0; b < LANE_W; b++) begin
        if (mag[b]) begin
          lead = LEAD_W'(b);
        end
      end
    end

    // Stage 1
    always_ff @(posedge clk) begin
      if (valid_i) begin
        s1_sign <= lane_in.int_val[LANE_W-1];
        s1_zero <= (mag == '0);
        s1_mag  <= mag;
        s1_lead <= lead;
      end
    end

    // Stage 2: leading one to bit 31, low bits dropped
    assign norm = s1_mag << (LEAD_W'(LANE_W - 1) - s1_lead);

    always_ff @(posedge clk) begin
      if (valid_s1) begin
        if (s1_zero) begin
          lane_out <= '0;
        end else begin
          lane_out.fp.sign <= s1_sign;
          lane_out.fp.exp  <= 8'(s1_lead) + 8'(FP_EXP_BIAS);
          lane_out.fp.mant <= norm[LANE_W-2 -: 23];
        end
      end
    end

    assign row_o[g*LANE_W +: LANE_W] = lane_out;
  end

endmodule

`default_nettype wire

/* source/fp_quantizer.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_quantizer import mlsu_pkg::*; #(
  parameter int NUM_LANES = 4
) (
  input  wire                        clk,
  input  wire                        rstnn,
  input  wire                        valid_i,
  input  wire [NUM_LANES*LANE_W-1:0] row_i,
  output logic                       valid_o,
  output wire [NUM_LANES*LANE_W-1:0] row_o
);

  logic valid_s1;

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      valid_s1 <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      valid_s1 <= valid_i;
      valid_o  <= valid_s1;
    end
  end

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_t      lane_in;
    lane_t      lane_out;
    logic [7:0] unb_exp;
    logic       s1_sign;
    logic       s1_zero;
    logic       s1_sat;
    logic [2:0] s1_shift;
    logic [7:0] s1_sig;
    logic [7:0] mag;
    logic [7:0] q;

    assign lane_in = row_i[g*LANE_W +: LANE_W];
    assign unb_exp = lane_in.fp.exp - 8'(FP_EXP_BIAS);

    // Stage 1: classify, keep the top of the significand
    always_ff @(posedge clk) begin
      if (valid_i) begin
        s1_sign  <= lane_in.fp.sign;
        s1_zero  <= lane_in.fp.exp < 8'(FP_EXP_BIAS);
        // Magnitude of 128 or more, infinity and NaN all land here
        s1_sat   <= lane_in.fp.exp >= 8'(FP_EXP_BIAS + 7);
        s1_shift <= unb_exp[2:0];
        s1_sig   <= {1'b1, lane_in.fp.mant[22:16]};
      end
    end

    // Stage 2: truncate to integer, then clamp
    assign mag = s1_sig >> (3'd7 - s1_shift);

    always_comb begin
      if (s1_sat) begin
        q = s1_sign ? 8'h80 : 8'h7f;
      end else if (s1_zero) begin
        q = '0;
      end else begin
        q = s1_sign ? -mag : mag;
      end
    end

    always_ff @(posedge clk) begin
      if (valid_s1) begin
        lane_out.int_val <= {{(LANE_W-8){q[7]}}, q};
      end
    end

    assign row_o[g*LANE_W +: LANE_W] = lane_out;
  end

endmodule

`default_nettype wire

/* source/lsu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer import mlsu_pkg::*; #(
  parameter int NUM_ROWS = 4
) (
  input  wire  clk,
  input  wire  rstnn,
  input  wire  start_i,
  input  wire  row_wvalid_i,
  output logic row_wready_o,
  output logic row_fire_o,
  input  wire  buf_full_i,
  input  wire  store_done_i,
  output logic idle_o
);

  localparam int CNT_W = $clog2(NUM_ROWS + 1);

  seq_state_t       state_q;
  seq_state_t       state_d;
  logic [CNT_W-1:0] row_cnt;

  // ----------------------------------------------------------------------
  // State machine
  // ----------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = LOAD;
        end
      end
      // Single setup cycle before rows are taken
      LOAD: state_d = EXEC;
      EXEC: begin
        if (buf_full_i) begin
          state_d = STORE;
        end
      end
      STORE: begin
        if (store_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Load side
  // ----------------------------------------------------------------------

  assign row_wready_o = (state_q == EXEC) && (row_cnt < CNT_W'(NUM_ROWS));
  assign row_fire_o   = row_wvalid_i & row_wready_o;
  assign idle_o       = (state_q == IDLE);

  // Accepted rows, cleared on the way into EXEC
  always_ff @(posedge clk or negedge rstnn) begin
    if (!rstnn) begin
      row_cnt <= '0;
    end else if (state_q == LOAD) begin
      row_cnt <= '0;
    end else if (row_fire_o) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/mlsu_pkg.sv */
`default_nettype none

package mlsu_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------

  localparam int LANE_W     = 32;
  localparam int INFO_W     = 16;
  localparam int OPC_W      = 2;
  localparam int INST_W     = 32;

  // LSU instruction is the info field sitting above the opcode
  localparam int LSU_INST_W = INFO_W + OPC_W;

  // LSU opcodes
  localparam logic [OPC_W-1:0] OPC_READ  = 2'd1;
  localparam logic [OPC_W-1:0] OPC_WRITE = 2'd2;

  // IEEE-754 single precision exponent bias
  localparam int FP_EXP_BIAS = 127;

  // ----------------------------------------------------------------------
  // Types
  // ----------------------------------------------------------------------

  // One row lane, seen either as FP32 fields or as a signed word
  typedef union packed {
    struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] mant;
    } fp;
    logic signed [LANE_W-1:0] int_val;
  } lane_t;

  // Per-path sequencer states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LOAD  = 2'd1,
    EXEC  = 2'd2,
    STORE = 2'd3
  } seq_state_t;

endpackage

`default_nettype wire
